/* include/interp_macros.svh */
// Attribute interpolator widths and timing
// Sizes of attribute words, coordinates and the framebuffer index,
// together with the fixed pipeline depth of the plane evaluation
`ifndef INTERP_MACROS_SVH
`define INTERP_MACROS_SVH

// One attribute word, signed 16.16 fixed point
`define ATTR_WIDTH 32
`define FRAC_BITS 16

// Screen and bounding-box coordinates
`define POS_WIDTH 16

// Framebuffer index of a pixel
`define FB_INDEX_WIDTH 32

// Cycles from an accepted beat to its output beat
`define INTERP_LATENCY 3

// Pixel-in-flight counter, holds 0 to INTERP_LATENCY
`define TRACK_WIDTH 3

`endif

/* logic/raster_stream_pkg.sv */
// Raster pixel stream types
// Beat layouts seen by the interpolator on its input side, and the fields
// that travel around the arithmetic to the output side
`include "interp_macros.svh"

package raster_stream_pkg;

    // x in the low half, y in the high half
    typedef struct packed {
        logic [`POS_WIDTH-1:0] y;
        logic [`POS_WIDTH-1:0] x;
    } screen_pos_t;

    typedef logic [`FB_INDEX_WIDTH-1:0] fb_index_t;

    // Input beat, bounding-box position in the lowest bits
    typedef struct packed {
        fb_index_t   fb_index;
        screen_pos_t screen_pos;
        screen_pos_t bbox_pos;
    } pixel_in_t;

    // Fields that bypass the plane evaluation
    typedef struct packed {
        screen_pos_t screen_pos;
        fb_index_t   fb_index;
        logic        last;
    } pixel_pass_t;

endpackage

/* logic/attrib_pkg.sv */
// Triangle attribute types
// Fixed-point attribute words, plane equations and the named sets of
// attributes that the interpolator evaluates for every pixel
`include "interp_macros.svh"

package attrib_pkg;

    // Number of interpolated attributes
    localparam int ATTR_COUNT = 7;

    // Signed 16.16 value, usable directly in arithmetic
    typedef struct packed signed {
        logic signed [`ATTR_WIDTH-`FRAC_BITS-1:0] int_part;
        logic        [`FRAC_BITS-1:0]             frac;
    } attr_t;

    // Plane equation: base + x * inc_x + y * inc_y
    typedef struct packed {
        attr_t base;
        attr_t inc_x;
        attr_t inc_y;
    } plane_t;

    typedef struct packed {
        attr_t depth_z;
        attr_t color_r;
        attr_t color_g;
        attr_t color_b;
        attr_t color_a;
        attr_t tex_s;
        attr_t tex_t;
    } attr_set_t;

    // Same field order as attr_set_t
    typedef struct packed {
        plane_t depth_z;
        plane_t color_r;
        plane_t color_g;
        plane_t color_b;
        plane_t color_a;
        plane_t tex_s;
        plane_t tex_t;
    } plane_set_t;

endpackage

/* logic/stream_delay_line.sv */
// Pass-through delay line
// Carries valid and the untouched beat fields for a fixed number of
// cycles so they line up with the plane evaluator results
`timescale 1ns/1ps
`include "interp_macros.svh"

module stream_delay_line #(
    parameter int DEPTH = `INTERP_LATENCY
) (
    input  logic                           aclk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  raster_stream_pkg::pixel_pass_t in_beat,
    output logic                           out_valid,
    output raster_stream_pkg::pixel_pass_t out_beat
);

    logic [DEPTH-1:0]               valid_sr;
    raster_stream_pkg::pixel_pass_t beat_sr [DEPTH];

    // Valid chain
    always_ff @(posedge aclk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    // Data chain, meaningful only where valid is set
    always_ff @(posedge aclk) begin
        beat_sr[0] <= in_beat;
        for (int i = 1; i < DEPTH; i++) begin
            beat_sr[i] <= beat_sr[i-1];
        end
    end

    assign out_valid = valid_sr[DEPTH-1];
    assign out_beat  = beat_sr[DEPTH-1];

    a_valid_known: assert property (@(posedge aclk) disable iff (rst) !$isunknown(out_valid))
        else $error("stream_delay_line: out_valid unknown");

endmodule

/* logic/plane_evaluator.sv */
// Plane equation evaluator for one attribute
// Computes base + x * inc_x + y * inc_y in signed 16.16 fixed point over
// three registered stages, so a new pixel can enter every cycle
`timescale 1ns/1ps
`include "interp_macros.svh"

module plane_evaluator (
    input  logic                           aclk,
    input  raster_stream_pkg::screen_pos_t bbox_pos,
    input  attrib_pkg::plane_t             plane,
    output attrib_pkg::attr_t              value
);

    localparam int STAGES = 3;
    localparam int EXT_BITS = `ATTR_WIDTH - `POS_WIDTH;

    // Stage count must agree with the pass-through delay line
    if (STAGES != `INTERP_LATENCY) begin : g_latency_check
        $error("plane_evaluator: stage count differs from INTERP_LATENCY");
    end

    // Offsets are non-negative integers, zero extended to a full word
    logic signed [`ATTR_WIDTH-1:0] off_x;
    logic signed [`ATTR_WIDTH-1:0] off_y;

    attrib_pkg::attr_t prod_x;
    attrib_pkg::attr_t prod_y;
    attrib_pkg::attr_t inc_sum;
    attrib_pkg::attr_t value_q;

    assign off_x = {{EXT_BITS{1'b0}}, bbox_pos.x};
    assign off_y = {{EXT_BITS{1'b0}}, bbox_pos.y};

    ////////////////////////////////////////////////////////////
    // Stage 1 offset times increment
    ////////////////////////////////////////////////////////////
    // Integer offset times 16.16 increment stays 16.16, low word kept
    always_ff @(posedge aclk) begin
        prod_x <= off_x * plane.inc_x;
        prod_y <= off_y * plane.inc_y;
    end

    ////////////////////////////////////////////////////////////
    // Stage 2 combined increment
    ////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        inc_sum <= prod_x + prod_y;
    end

    ////////////////////////////////////////////////////////////
    // Stage 3 add base
    ////////////////////////////////////////////////////////////
    // Base is a level held by the rasterizer, no need to delay it
    always_ff @(posedge aclk) begin
        value_q <= inc_sum + plane.base;
    end

    assign value = value_q;

endmodule

/* logic/pixel_tracker.sv */
// Pixels-in-flight tracker
// Counts beats entering and leaving the interpolator and raises a
// registered level while at least one pixel is inside
`timescale 1ns/1ps
`include "interp_macros.svh"

module pixel_tracker (
    input  logic aclk,
    input  logic rst,
    input  logic pixel_in,
    input  logic pixel_out,
    output logic pixel_in_pipeline
);

    logic [`TRACK_WIDTH-1:0] count;
    logic [`TRACK_WIDTH-1:0] count_next;

    // Simultaneous entry and exit leave the count alone
    always_comb begin
        case ({pixel_in, pixel_out})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            count             <= '0;
            pixel_in_pipeline <= 1'b0;
        end else begin
            count             <= count_next;
            pixel_in_pipeline <= (count_next != '0);
        end
    end

    // An exit without a matching entry
    a_no_underflow: assert property (@(posedge aclk) disable iff (rst)
        (pixel_out && !pixel_in) |-> (count != '0))
        else $error("pixel_tracker: count underflow");

    // Pipeline cannot hold more pixels than it has stages
    a_bounded: assert property (@(posedge aclk) disable iff (rst)
        count <= `INTERP_LATENCY)
        else $error("pixel_tracker: more pixels in flight than stages");

endmodule

/* logic/attribute_interpolator.sv */
// Attribute interpolator top level
// Evaluates the plane equation of every triangle attribute for each pixel
// beat and forwards position, framebuffer index and last alongside
`timescale 1ns/1ps
`include "interp_macros.svh"

module attribute_interpolator (
    input  logic                           aclk,
    input  logic                           rst,

    // Pixel stream from the rasterizer
    input  logic                           s_valid,
    input  logic                           s_last,
    input  raster_stream_pkg::pixel_in_t   s_pixel,

    // Triangle planes, stable while pixels are in flight
    input  attrib_pkg::plane_set_t         planes,

    // Interpolated pixel stream
    output logic                           m_valid,
    output logic                           m_last,
    output raster_stream_pkg::screen_pos_t m_screen_pos,
    output raster_stream_pkg::fb_index_t   m_fb_index,
    output attrib_pkg::attr_set_t          m_attrs,

    output logic                           pixel_in_pipeline
);

    raster_stream_pkg::pixel_pass_t pass_in;
    raster_stream_pkg::pixel_pass_t pass_out;
    logic                           pass_valid;

    // Named fields viewed as arrays, same bit layout
    attrib_pkg::plane_t [attrib_pkg::ATTR_COUNT-1:0] plane_vec;
    attrib_pkg::attr_t  [attrib_pkg::ATTR_COUNT-1:0] value_vec;

    ////////////////////////////////////////////////////////////
    // Pass-through fields
    ////////////////////////////////////////////////////////////
    assign pass_in.screen_pos = s_pixel.screen_pos;
    assign pass_in.fb_index   = s_pixel.fb_index;
    assign pass_in.last       = s_last;

    stream_delay_line #(
        .DEPTH(`INTERP_LATENCY)
    ) delay_i (
        .aclk(aclk),
        .rst(rst),
        .in_valid(s_valid),
        .in_beat(pass_in),
        .out_valid(pass_valid),
        .out_beat(pass_out)
    );

    ////////////////////////////////////////////////////////////
    // Plane evaluation, one evaluator per attribute
    ////////////////////////////////////////////////////////////
    assign plane_vec = planes;

    for (genvar i = 0; i < attrib_pkg::ATTR_COUNT; i++) begin : g_attr
        plane_evaluator eval_i (
            .aclk(aclk),
            .bbox_pos(s_pixel.bbox_pos),
            .plane(plane_vec[i]),
            .value(value_vec[i])
        );
    end

    ////////////////////////////////////////////////////////////
    // In-flight tracking
    ////////////////////////////////////////////////////////////
    pixel_tracker tracker_i (
        .aclk(aclk),
        .rst(rst),
        .pixel_in(s_valid),
        .pixel_out(pass_valid),
        .pixel_in_pipeline(pixel_in_pipeline)
    );

    // Output beat
    assign m_valid      = pass_valid;
    assign m_last       = pass_out.last;
    assign m_screen_pos = pass_out.screen_pos;
    assign m_fb_index   = pass_out.fb_index;
    assign m_attrs      = value_vec;

endmodule

/* bench/interp_tb.sv */
// Attribute interpolator testbench
// Directed tests for reset, latency, random bursts, wrap-around, gapped
// streams and the pixel-in-pipeline level, checked against a plane model
`timescale 1ns/1ps
`include "interp_macros.svh"

module interp_tb;

    localparam int RESET_CYCLES = 10;
    localparam int CYCLE_LIMIT  = 2000;
    localparam int N            = attrib_pkg::ATTR_COUNT;

    // Expected output beat, built when the input beat is driven
    typedef struct packed {
        logic                           last;
        raster_stream_pkg::screen_pos_t screen_pos;
        raster_stream_pkg::fb_index_t   fb_index;
        attrib_pkg::attr_set_t          attrs;
    } out_beat_t;

    logic                           aclk = 1'b0;
    logic                           rst;
    logic                           s_valid;
    logic                           s_last;
    raster_stream_pkg::pixel_in_t   s_pixel;
    attrib_pkg::plane_set_t         planes;
    logic                           m_valid;
    logic                           m_last;
    raster_stream_pkg::screen_pos_t m_screen_pos;
    raster_stream_pkg::fb_index_t   m_fb_index;
    attrib_pkg::attr_set_t          m_attrs;
    logic                           pixel_in_pipeline;

    integer    seed = 32'h76e5;
    out_beat_t expected_q[$];
    string     cur_test = "none";
    int        errors = 0;
    int        test_errors_start = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        cycle_count = 0;

    always #4 aclk = ~aclk;

    attribute_interpolator dut_i (
        .aclk(aclk),
        .rst(rst),
        .s_valid(s_valid),
        .s_last(s_last),
        .s_pixel(s_pixel),
        .planes(planes),
        .m_valid(m_valid),
        .m_last(m_last),
        .m_screen_pos(m_screen_pos),
        .m_fb_index(m_fb_index),
        .m_attrs(m_attrs),
        .pixel_in_pipeline(pixel_in_pipeline)
    );

    ////////////////////////////////////////////////////////////
    // Reference model and reporting
    ////////////////////////////////////////////////////////////
    // base + x * inc_x + y * inc_y, offsets zero extended, wraps mod 2^32
    function automatic logic [`ATTR_WIDTH-1:0] plane_value(
        input attrib_pkg::plane_t p,
        input raster_stream_pkg::screen_pos_t pos
    );
        logic [`ATTR_WIDTH-1:0] x_ext;
        logic [`ATTR_WIDTH-1:0] y_ext;
        logic [`ATTR_WIDTH-1:0] sum;
        x_ext = {{(`ATTR_WIDTH-`POS_WIDTH){1'b0}}, pos.x};
        y_ext = {{(`ATTR_WIDTH-`POS_WIDTH){1'b0}}, pos.y};
        sum = p.base + x_ext * p.inc_x + y_ext * p.inc_y;
        return sum;
    endfunction

    function automatic string attr_name(input int i);
        case (i)
            6:       return "depth_z";
            5:       return "color_r";
            4:       return "color_g";
            3:       return "color_b";
            2:       return "color_a";
            1:       return "tex_s";
            default: return "tex_t";
        endcase
    endfunction

    task automatic report_value(input string what, input logic [`ATTR_WIDTH-1:0] expected,
                                input logic [`ATTR_WIDTH-1:0] actual);
        $display("Error %s: %s expected %h actual %h", cur_test, what, expected, actual);
        errors++;
    endtask

    // Compare each output beat with the oldest outstanding expectation
    always @(negedge aclk) begin : check_output
        out_beat_t                       exp_b;
        attrib_pkg::attr_t [N-1:0]       exp_v;
        attrib_pkg::attr_t [N-1:0]       act_v;
        if (rst === 1'b0 && m_valid === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("Error %s: output beat appeared with no pixel outstanding", cur_test);
                errors++;
            end else begin
                exp_b = expected_q.pop_front();
                exp_v = exp_b.attrs;
                act_v = m_attrs;
                if (m_last !== exp_b.last)
                    report_value("m_last", exp_b.last, m_last);
                if (m_screen_pos !== exp_b.screen_pos)
                    report_value("m_screen_pos", exp_b.screen_pos, m_screen_pos);
                if (m_fb_index !== exp_b.fb_index)
                    report_value("m_fb_index", exp_b.fb_index, m_fb_index);
                for (int i = 0; i < N; i++) begin
                    if (act_v[i] !== exp_v[i])
                        report_value(attr_name(i), exp_v[i], act_v[i]);
                end
            end
        end
    end

    // Run limit, well above what the tests need
    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout in %s: run went past %0d cycles", cur_test, CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////
    task automatic begin_test(input string name);
        cur_test = name;
        test_errors_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors_start) begin
            $display("Test %s: passed", cur_test);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", cur_test, errors - test_errors_start);
        end
    endtask

    // Planes may only change while the pipeline is empty
    task automatic load_planes(input attrib_pkg::plane_set_t value);
        @(posedge aclk);
        planes <= value;
    endtask

    task automatic randomize_planes();
        attrib_pkg::plane_t [N-1:0] pv;
        for (int i = 0; i < N; i++) begin
            pv[i].base  = $random(seed);
            pv[i].inc_x = $random(seed);
            pv[i].inc_y = $random(seed);
        end
        load_planes(pv);
    endtask

    task automatic random_pixel(output raster_stream_pkg::pixel_in_t p);
        p.bbox_pos   = $random(seed);
        p.screen_pos = $random(seed);
        p.fb_index   = $random(seed);
    endtask

    // One beat on the next edge, expectation taken from the model
    task automatic drive_pixel(input raster_stream_pkg::pixel_in_t p, input logic last);
        out_beat_t e;
        attrib_pkg::plane_t [N-1:0] pv;
        attrib_pkg::attr_t  [N-1:0] av;
        @(posedge aclk);
        s_valid <= 1'b1;
        s_last  <= last;
        s_pixel <= p;
        pv = planes;
        for (int i = 0; i < N; i++) begin
            av[i] = plane_value(pv[i], p.bbox_pos);
        end
        e.last       = last;
        e.screen_pos = p.screen_pos;
        e.fb_index   = p.fb_index;
        e.attrs      = av;
        expected_q.push_back(e);
    endtask

    task automatic drive_idle();
        @(posedge aclk);
        s_valid <= 1'b0;
        s_last  <= 1'b0;
    endtask

    task automatic finish_stream();
        drive_idle();
        while (expected_q.size() != 0) begin
            @(posedge aclk);
        end
    endtask

    task automatic check_idle(input string when);
        if (m_valid !== 1'b0)
            report_value({"m_valid ", when}, 0, m_valid);
        if (m_last !== 1'b0)
            report_value({"m_last ", when}, 0, m_last);
        if (pixel_in_pipeline !== 1'b0)
            report_value({"pixel_in_pipeline ", when}, 0, pixel_in_pipeline);
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////
    task automatic test_reset();
        begin_test("reset");
        @(posedge aclk);
        rst <= 1'b1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge aclk);
            // The unreset data chain holds s_last low once it has filled
            if (i >= `INTERP_LATENCY)
                check_idle("during reset");
            @(posedge aclk);
        end
        rst <= 1'b0;
        repeat (2) begin
            @(negedge aclk);
            check_idle("after reset");
        end
        end_test();
    endtask

    task automatic test_single_origin();
        raster_stream_pkg::pixel_in_t p;
        attrib_pkg::plane_t [N-1:0]   pv;
        attrib_pkg::attr_t  [N-1:0]   act_v;
        begin_test("single_origin");
        randomize_planes();
        random_pixel(p);
        p.bbox_pos = '0;
        drive_pixel(p, 1'b1);
        drive_idle();
        // Beat was sampled on the edge just passed, third register shows it
        for (int i = 0; i < `INTERP_LATENCY - 1; i++) begin
            @(negedge aclk);
            if (m_valid !== 1'b0) begin
                $display("Error %s: m_valid rose %0d cycles after the beat", cur_test, i);
                errors++;
            end
        end
        @(negedge aclk);
        if (m_valid !== 1'b1) begin
            $display("Error %s: m_valid did not rise three cycles after the beat", cur_test);
            errors++;
        end
        pv = planes;
        act_v = m_attrs;
        for (int i = 0; i < N; i++) begin
            if (act_v[i] !== pv[i].base)
                report_value({attr_name(i), " base"}, pv[i].base, act_v[i]);
        end
        finish_stream();
        end_test();
    endtask

    task automatic test_random_burst();
        raster_stream_pkg::pixel_in_t p;
        begin_test("random_burst");
        randomize_planes();
        for (int i = 0; i < 20; i++) begin
            random_pixel(p);
            drive_pixel(p, i == 19);
        end
        finish_stream();
        end_test();
    endtask

    task automatic test_wrap_negative();
        attrib_pkg::plane_t [N-1:0]   pv;
        raster_stream_pkg::pixel_in_t p;
        logic [`POS_WIDTH-1:0]        xs[4] = '{16'hffff, 16'h8000, 16'h0001, 16'hffff};
        logic [`POS_WIDTH-1:0]        ys[4] = '{16'hffff, 16'h0001, 16'h7fff, 16'h0000};
        begin_test("wrap_negative");
        for (int i = 0; i < N; i++) begin
            pv[i].base  = 32'h7fff_0000 - i * 32'h0001_3000;
            pv[i].inc_x = 32'hffff_0000 - i * 32'h0021_0000;
            pv[i].inc_y = 32'hc000_0000 + i * 32'h0000_1234;
        end
        load_planes(pv);
        for (int i = 0; i < 8; i++) begin
            random_pixel(p);
            if (i < 4) begin
                p.bbox_pos.x = xs[i];
                p.bbox_pos.y = ys[i];
            end else begin
                // Keep offsets near the top of their range
                p.bbox_pos.x[`POS_WIDTH-1] = 1'b1;
                p.bbox_pos.y[`POS_WIDTH-1] = 1'b1;
            end
            drive_pixel(p, i == 7);
        end
        finish_stream();
        end_test();
    endtask

    task automatic test_gapped_stream();
        raster_stream_pkg::pixel_in_t p;
        int                           gap;
        begin_test("gapped_stream");
        randomize_planes();
        for (int i = 0; i < 15; i++) begin
            random_pixel(p);
            drive_pixel(p, i == 14);
            gap = $random(seed) & 3;
            repeat (gap) drive_idle();
        end
        finish_stream();
        end_test();
    endtask

    task automatic test_pipeline_level();
        raster_stream_pkg::pixel_in_t p;
        int                           seen;
        begin_test("pipeline_level");
        random_pixel(p);
        drive_pixel(p, 1'b0);
        @(negedge aclk);
        if (pixel_in_pipeline !== 1'b0)
            report_value("pixel_in_pipeline before first accept", 0, pixel_in_pipeline);
        random_pixel(p);
        drive_pixel(p, 1'b0);
        @(negedge aclk);
        if (pixel_in_pipeline !== 1'b1)
            report_value("pixel_in_pipeline after first accept", 1, pixel_in_pipeline);
        random_pixel(p);
        drive_pixel(p, 1'b1);
        drive_idle();
        seen = 0;
        while (seen < 3) begin
            @(negedge aclk);
            if (pixel_in_pipeline !== 1'b1)
                report_value("pixel_in_pipeline in flight", 1, pixel_in_pipeline);
            if (m_valid === 1'b1)
                seen++;
        end
        @(negedge aclk);
        if (pixel_in_pipeline !== 1'b0)
            report_value("pixel_in_pipeline after last output", 0, pixel_in_pipeline);
        end_test();
    endtask

    initial begin
        rst     = 1'b1;
        s_valid = 1'b0;
        s_last  = 1'b0;
        s_pixel = '0;
        planes  = '0;
        test_reset();
        test_single_origin();
        test_random_burst();
        test_wrap_negative();
        test_gapped_stream();
        test_pipeline_level();
        $display("Summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* attribute_interp.f */
+incdir+include
logic/raster_stream_pkg.sv
logic/attrib_pkg.sv
logic/stream_delay_line.sv
logic/plane_evaluator.sv
logic/pixel_tracker.sv
logic/attribute_interpolator.sv
bench/interp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the attribute interpolator testbench with Verilator and run it.
# The run fails if the log reports a failing test or the build breaks.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module interp_tb \
    -f attribute_interp.f -o interp_sim > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/interp_sim > "$LOG" 2>&1 \
    || { cat "$BUILD_LOG"; echo "Build or simulation run failed"; exit 1; }

cat "$LOG"
grep -q "SOME TESTS FAILED" "$LOG" && { echo "Simulation reported failures"; exit 1; }
echo "Simulation finished without failures"
exit 0
